/* cache_config.svh */
// Geometry of the direct-mapped byte cache and widths of its memory bus.
// Included by the packages and by every cache module.
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Processor byte address is tag, index, offset.
`define CACHE_TAG_W     8
`define CACHE_INDEX_W   6
`define CACHE_OFFSET_W  2
`define CACHE_ADDR_W    16
`define CACHE_LINES     64   // One 32-bit word per line.

// Memory side addresses whole words, tag and index joined.
`define MEM_WORD_W      32
`define MEM_ADDR_W      14

`endif

/* cache_pkg.sv */
// Processor-side types of the cache: address fields, the registered request
// and the controller states.
`default_nettype none

`include "cache_config.svh"

package cache_pkg;

  typedef logic [`CACHE_ADDR_W-1:0]   cache_addr_t;
  typedef logic [`CACHE_TAG_W-1:0]    tag_t;
  typedef logic [`CACHE_INDEX_W-1:0]  index_t;
  typedef logic [`CACHE_OFFSET_W-1:0] offset_t;
  typedef logic [7:0]                 byte_t;

  // Same bit layout as cache_addr_t, so an address casts straight to it.
  typedef struct packed {
    tag_t    tag;
    index_t  index;
    offset_t offset;
  } cache_req_t;

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_respond,
    st_refill,
    st_fill
  } ctrl_state_t;

endpackage

`default_nettype wire

/* mem_pkg.sv */
// Word-wide memory bus types shared by the controller and the top level.
`default_nettype none

`include "cache_config.svh"

package mem_pkg;

  typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;
  typedef logic [`MEM_WORD_W-1:0] mem_word_t;

  // Strobe holds with a fixed address until the ack cycle.
  typedef struct packed {
    logic      stb;
    mem_addr_t addr;
  } mem_req_t;

endpackage

`default_nettype wire

/* cache_tags.sv */
// Valid bits and tag array of the cache. Looks up one line per edge and
// compares against the registered request tag.
`timescale 1ns/10ps
`default_nettype none

`include "cache_config.svh"

module cache_tags (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  flush_lines,
  input  cache_pkg::index_t     lookup_index,
  input  cache_pkg::cache_req_t req,
  input  logic                  fill,
  output logic                  hit
);
  import cache_pkg::*;

  logic [`CACHE_LINES-1:0] valid;
  tag_t                    tags [`CACHE_LINES];
  logic                    valid_q;   // Valid bit of the looked-up line.
  tag_t                    tag_q;

  // Flush and reset drop every line at once.
  always_ff @(posedge clk) begin
    if (reset || flush_lines) begin
      valid <= '0;
    end else if (fill) begin
      valid[req.index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill) begin
      tags[req.index] <= req.tag;
    end
  end

  // A flush in the accept cycle must not leave a stale valid behind.
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid[lookup_index] & ~flush_lines;
    end
  end

  always_ff @(posedge clk) begin
    tag_q <= tags[lookup_index];
  end

  assign hit = valid_q && (tag_q == req.tag);

endmodule

`default_nettype wire

/* cache_data.sv */
// Word store of the cache. Reads one word per edge and hands out the byte
// picked by the request offset, first byte in the top bits.
`timescale 1ns/10ps
`default_nettype none

`include "cache_config.svh"

module cache_data (
  input  logic                  clk,
  input  cache_pkg::index_t     lookup_index,
  input  cache_pkg::cache_req_t req,
  input  logic                  fill,
  input  mem_pkg::mem_word_t    fill_word,
  output cache_pkg::byte_t      data
);
  import mem_pkg::*;

  mem_word_t words [`CACHE_LINES];
  mem_word_t rd_word;
  mem_word_t word;
  logic      bypass;   // Read in the fill edge still saw the old word.

  always_ff @(posedge clk) begin
    if (fill) begin
      words[req.index] <= fill_word;
    end
  end

  always_ff @(posedge clk) begin
    rd_word <= words[lookup_index];
    bypass  <= fill;
  end

  assign word = bypass ? fill_word : rd_word;

  // Big-endian byte select.
  always_comb begin
    case (req.offset)
      2'd0:    data = word[31:24];
      2'd1:    data = word[23:16];
      2'd2:    data = word[15:8];
      default: data = word[7:0];
    endcase
  end

endmodule

`default_nettype wire

/* cache_ctrl.sv */
// Cache controller FSM. Accepts one processor request at a time, answers hits
// from the stores and refills misses over the memory strobe/ack bus.
`timescale 1ns/10ps
`default_nettype none

`include "cache_config.svh"

module cache_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   cache_valid_in,
  input  cache_pkg::cache_addr_t cache_addr_in,
  output logic                   cache_ready_out,
  input  logic                   cache_ready_in,
  output logic                   cache_valid_out,
  input  logic                   flush,
  input  logic                   hit,
  output cache_pkg::cache_req_t  req,
  output cache_pkg::index_t      lookup_index,
  output logic                   fill,
  output mem_pkg::mem_word_t     fill_word,
  output logic                   flush_lines,
  output mem_pkg::mem_req_t      mem_req,
  input  mem_pkg::mem_word_t     memory_data,
  input  logic                   memory_ack
);
  import cache_pkg::*;
  import mem_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_next;
  cache_req_t  new_req;
  logic        accept;
  logic        flush_pending;

  assign new_req = cache_req_t'(cache_addr_in);   // Split into tag, index, offset.

  assign cache_ready_out = (state == st_idle);
  assign cache_valid_out = (state == st_respond);
  assign accept          = cache_valid_in && cache_ready_out;

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (accept) begin
          state_next = st_lookup;
        end
      end
      st_lookup: begin
        state_next = hit ? st_respond : st_refill;
      end
      st_refill: begin
        if (memory_ack) begin
          state_next = st_fill;
        end
      end
      st_fill: begin
        state_next = st_respond;   // Line written, bypass covers the read.
      end
      st_respond: begin
        if (cache_ready_in) begin
          state_next = st_idle;
        end
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  // Request fields stay put until the next accept.
  always_ff @(posedge clk) begin
    if (accept) begin
      req <= new_req;
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_refill && memory_ack) begin
      fill_word <= memory_data;
    end
  end

  // A flush that arrives mid-request waits for idle.
  always_ff @(posedge clk) begin
    if (reset) begin
      flush_pending <= 1'b0;
    end else if (state == st_idle) begin
      flush_pending <= 1'b0;
    end else if (flush) begin
      flush_pending <= 1'b1;
    end
  end

  assign flush_lines = (state == st_idle) && (flush || flush_pending);

  // Stores read the incoming line while idle so the result is ready in lookup.
  assign lookup_index = (state == st_idle) ? new_req.index : req.index;

  assign fill = (state == st_fill);

  // Strobe is high for the whole refill state, address from the held request.
  assign mem_req = '{stb: (state == st_refill), addr: mem_addr_t'({req.tag, req.index})};

endmodule

`default_nettype wire

/* cache_top.sv */
// Top level of the read-only byte cache. Connects the controller and the two
// stores to the processor port and the memory bus.
`timescale 1ns/10ps
`default_nettype none

`include "cache_config.svh"

module cache_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   cache_valid_in,
  input  cache_pkg::cache_addr_t cache_addr_in,
  output logic                   cache_ready_out,
  input  logic                   cache_ready_in,
  output logic                   cache_valid_out,
  output cache_pkg::byte_t       cache_data_out,
  input  logic                   flush,
  output mem_pkg::mem_req_t      mem_req,
  input  mem_pkg::mem_word_t     memory_data,
  input  logic                   memory_ack
);
  import cache_pkg::*;
  import mem_pkg::*;

  cache_req_t req;
  index_t     lookup_index;
  mem_word_t  fill_word;
  logic       fill;
  logic       flush_lines;
  logic       hit;

  cache_ctrl i_cache_ctrl (
    .clk             (clk),
    .reset           (reset),
    .cache_valid_in  (cache_valid_in),
    .cache_addr_in   (cache_addr_in),
    .cache_ready_out (cache_ready_out),
    .cache_ready_in  (cache_ready_in),
    .cache_valid_out (cache_valid_out),
    .flush           (flush),
    .hit             (hit),
    .req             (req),
    .lookup_index    (lookup_index),
    .fill            (fill),
    .fill_word       (fill_word),
    .flush_lines     (flush_lines),
    .mem_req         (mem_req),
    .memory_data     (memory_data),
    .memory_ack      (memory_ack)
  );

  cache_tags i_cache_tags (
    .clk          (clk),
    .reset        (reset),
    .flush_lines  (flush_lines),
    .lookup_index (lookup_index),
    .req          (req),
    .fill         (fill),
    .hit          (hit)
  );

  cache_data i_cache_data (
    .clk          (clk),
    .lookup_index (lookup_index),
    .req          (req),
    .fill         (fill),
    .fill_word    (fill_word),
    .data         (cache_data_out)
  );

endmodule

`default_nettype wire

/* cache_checker.sv */
// Assertions on the processor handshakes and the memory bus of the cache.
// Bound into every cache_top instance.
`timescale 1ns/10ps
`default_nettype none

module cache_checker (
  input logic              clk,
  input logic              reset,
  input logic              cache_ready_out,
  input logic              cache_valid_out,
  input logic              cache_ready_in,
  input cache_pkg::byte_t  cache_data_out,
  input mem_pkg::mem_req_t mem_req,
  input logic              memory_ack
);
  int fails = 0;   // Failure count, read by the testbench.

  a_stb_hold: assert property (@(posedge clk) disable iff (reset)
    mem_req.stb && !memory_ack |=> mem_req.stb && $stable(mem_req.addr))
    else begin
      $error("Memory strobe or address changed before ack");
      fails++;
    end

  // Response holds while the processor stalls.
  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    cache_valid_out && !cache_ready_in |=> cache_valid_out && $stable(cache_data_out))
    else begin
      $error("Response changed while stalled");
      fails++;
    end

  a_ready_valid: assert property (@(posedge clk) disable iff (reset)
    !(cache_ready_out && cache_valid_out))
    else begin
      $error("Request ready and response valid high together");
      fails++;
    end

  a_reset_stb: assert property (@(posedge clk)
    reset && ($past(reset) === 1'b1) |-> !mem_req.stb)
    else begin
      $error("Memory strobe high during reset");
      fails++;
    end

endmodule

bind cache_top cache_checker i_cache_checker (
  .clk             (clk),
  .reset           (reset),
  .cache_ready_out (cache_ready_out),
  .cache_valid_out (cache_valid_out),
  .cache_ready_in  (cache_ready_in),
  .cache_data_out  (cache_data_out),
  .mem_req         (mem_req),
  .memory_ack      (memory_ack)
);

`default_nettype wire

/* tb_cache.sv */
// Testbench for the read-only byte cache. Plays main memory and applies a table of
// reads, checking bytes, hit/miss behavior, strobe addresses and back-pressure.
`timescale 1ns/10ps
`default_nettype none

`include "cache_config.svh"

module tb_cache;
  import cache_pkg::*;
  import mem_pkg::*;

  typedef struct packed {
    cache_addr_t addr;
    logic        flush;
    logic [3:0]  stall;   // Cycles with cache_ready_in held low.
    logic        miss;
  } row_t;

  localparam int WAIT_LIMIT = 100;

  logic        clk;
  logic        reset;
  logic        cache_valid_in;
  cache_addr_t cache_addr_in;
  logic        cache_ready_out;
  logic        cache_ready_in;
  logic        cache_valid_out;
  byte_t       cache_data_out;
  logic        flush;
  mem_req_t    mem_req;
  mem_word_t   memory_data;
  logic        memory_ack;

  mem_word_t               mem [1 << `MEM_ADDR_W];
  logic [31:0]             lfsr = 32'h3ddf;
  int                      strobe_count;
  mem_addr_t               last_stb_addr;
  int                      err_count;
  int                      timeout_count;
  row_t                    rows [$];
  logic [`CACHE_LINES-1:0] shadow_valid;
  tag_t                    shadow_tag [`CACHE_LINES];

  cache_top i_cache_top (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Galois LFSR, one step per bit taken.
  task automatic take_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // Main memory. Ack comes 1 to 4 cycles after the strobe.
  initial begin
    logic [31:0] delay;
    memory_ack  = 1'b0;
    memory_data = '0;
    forever begin
      @(posedge clk);
      #1;
      if (mem_req.stb === 1'b1) begin
        strobe_count++;
        last_stb_addr = mem_req.addr;
        take_bits(2, delay);
        repeat (delay + 1) @(posedge clk);
        #1;
        memory_ack  = 1'b1;
        memory_data = mem[mem_req.addr];
        @(posedge clk);
        #1;
        memory_ack  = 1'b0;
      end
    end
  end

  // Direct-mapped shadow: tag is addr[15:8], line is addr[7:2].
  task automatic add_row(input cache_addr_t addr, input logic fl, input logic [3:0] stall);
    row_t r;
    if (fl) shadow_valid = '0;
    r.addr  = addr;
    r.flush = fl;
    r.stall = stall;
    r.miss  = !shadow_valid[addr[7:2]] || (shadow_tag[addr[7:2]] != addr[15:8]);
    shadow_valid[addr[7:2]] = 1'b1;
    shadow_tag[addr[7:2]]   = addr[15:8];
    rows.push_back(r);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("ERR %s got %h expected %h", name, got, want);
      err_count++;
    end
  endtask

  task automatic run_row(input row_t r);
    int        t;
    int        i;
    int        start_count;
    mem_word_t w;
    byte_t     want;
    w    = mem[r.addr[15:2]];
    want = w[8 * (3 - r.addr[1:0]) +: 8];   // Offset 0 is the top byte.
    if (r.flush) begin
      flush = 1'b1;
      @(posedge clk);
      #1;
      flush = 1'b0;
    end
    t = 0;
    while (cache_ready_out !== 1'b1 && t < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      t++;
    end
    if (cache_ready_out !== 1'b1) begin
      $display("The cache never became ready for address %h.", r.addr);
      timeout_count++;
      return;
    end
    start_count    = strobe_count;
    cache_valid_in = 1'b1;
    cache_addr_in  = r.addr;
    @(posedge clk);
    #1;
    cache_valid_in = 1'b0;
    t = 0;
    while (cache_valid_out !== 1'b1 && t < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      t++;
    end
    if (cache_valid_out !== 1'b1) begin
      $display("No response arrived for address %h.", r.addr);
      timeout_count++;
      return;
    end
    if (!r.miss) check("hit_latency", t, 1);
    cache_valid_in = 1'b1;   // Competing request that must wait.
    cache_addr_in  = r.addr ^ 16'hff00;
    for (i = 0; i <= r.stall; i++) begin
      if (i == r.stall) cache_ready_in = 1'b1;
      check("cache_valid_out", cache_valid_out, 1);
      check("cache_data_out", cache_data_out, want);
      check("cache_ready_out", cache_ready_out, 0);   // Nothing accepted while busy.
      @(posedge clk);
      #1;
    end
    cache_valid_in = 1'b0;
    cache_ready_in = 1'b0;
    check("cache_ready_out", cache_ready_out, 1);
    check("cache_valid_out", cache_valid_out, 0);
    check("strobe_count", strobe_count - start_count, r.miss);
    if (r.miss) check("mem_req.addr", last_stb_addr, r.addr[15:2]);
  endtask

  initial begin
    int          i;
    logic [31:0] v;
    reset          = 1'b1;
    cache_valid_in = 1'b0;
    cache_addr_in  = '0;
    cache_ready_in = 1'b0;
    flush          = 1'b0;
    strobe_count   = 0;
    err_count      = 0;
    timeout_count  = 0;
    shadow_valid   = '0;
    for (i = 0; i < (1 << `MEM_ADDR_W); i++) begin
      take_bits(32, v);
      mem[i] = v;
    end
    add_row(16'h1234, 1'b0, 4'd0);   // Cold miss, then the other offsets hit.
    add_row(16'h1235, 1'b0, 4'd0);
    add_row(16'h1236, 1'b0, 4'd2);
    add_row(16'h1237, 1'b0, 4'd0);
    add_row(16'h5637, 1'b0, 4'd1);   // Same line, new tag evicts.
    add_row(16'h1234, 1'b0, 4'd0);
    add_row(16'h2000, 1'b0, 4'd0);
    add_row(16'h2001, 1'b0, 4'd3);
    add_row(16'h1232, 1'b0, 4'd0);
    add_row(16'h1233, 1'b1, 4'd0);   // Flush drops every line.
    add_row(16'h2002, 1'b0, 4'd5);
    add_row(16'h3000, 1'b0, 4'd4);
    for (i = 0; i < 24; i++) begin
      take_bits(8, v);   // Four tags over four lines.
      add_row({6'h10, v[7:6], 4'h2, v[5:4], v[3:2]}, 1'b0, {2'b00, v[1:0]});
    end
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    for (i = 0; i < 3; i++) begin
      check("cache_ready_out", cache_ready_out, 1);
      check("cache_valid_out", cache_valid_out, 0);
      check("mem_req.stb", mem_req.stb, 0);
      @(posedge clk);
      #1;
    end
    foreach (rows[i]) run_row(rows[i]);
    $display("Rows %0d, value errors %0d, timeouts %0d, assertion failures %0d",
             rows.size(), err_count, timeout_count, i_cache_top.i_cache_checker.fails);
    if (err_count == 0 && timeout_count == 0 && i_cache_top.i_cache_checker.fails == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* cache.f */
+incdir+.
cache_pkg.sv
mem_pkg.sv
cache_tags.sv
cache_data.sv
cache_ctrl.sv
cache_top.sv
cache_checker.sv
tb_cache.sv

/* Bender.yml */
package:
  name: cache

sources:
  - include_dirs:
      - .
    files:
      - cache_pkg.sv
      - mem_pkg.sv
      - cache_tags.sv
      - cache_data.sv
      - cache_ctrl.sv
      - cache_top.sv
      - target: test
        files:
          - cache_checker.sv
          - tb_cache.sv
